// ==== src.f ====
+incdir+.
pel_pkg.sv
pec.sv
peb.sv
pel.sv
tb_pel.sv

// ==== pel_trace.txt ====
# W blk col wflags w0..w3 | A marks(frt_blk frt_row val) aflags a0..a3 | R blk addr expected
# D idle | F finish frame | T next test | flags run from channel 3 down to channel 0
W 0 0 1111 1 2 0 1
W 0 1 1111 0 1 1 0
W 0 2 1111 1 0 -1 1
W 1 0 1111 2 0 0 0
W 1 1 1111 0 0 3 0
W 1 2 1111 1 1 1 1
T 2
A 111 1111 0 1 0 2
A 001 1111 1 1 1 2
A 001 1111 2 1 2 2
A 001 1111 3 1 3 2
A 001 1111 4 1 4 2
A 001 1111 5 1 5 2
D
R 0 0 8
R 0 3 14
R 1 0 10
R 1 3 31
T 3
A 111 0101 0 9 0 9
A 001 0101 1 9 1 9
A 001 0101 2 9 2 9
A 001 0101 3 9 3 9
D
R 0 1 3
R 1 2 13
T 4
A 010 1111 0 1 0 2
A 000 1111 1 1 1 2
A 001 1111 2 1 2 2
A 001 1111 3 1 3 2
D
R 0 0 3
R 0 2 15
R 1 1 29
T 5
A 111 1111 1 1 1 1
A 001 1111 1 1 1 1
A 001 1111 1 1 1 1
A 011 1111 2 0 0 0
A 001 1111 0 2 0 0
A 001 1111 0 0 2 0
D
R 0 0 9
R 1 1 11
A 110 1111 5 5 5 5
D
R 0 1 0
R 1 0 0
T 6
F
W 0 0 0011 1 1 7 7
W 0 1 1111 1 0 0 0
W 0 2 1000 5 5 5 -1
W 1 0 1111 0 0 0 1
W 1 1 0110 4 1 1 4
W 1 2 0001 2 3 3 3
A 111 1111 0 1 2 0
A 001 1111 1 1 2 1
A 001 1111 2 1 2 2
A 001 1111 3 1 2 3
D
R 0 1 1
R 0 2 6
R 1 0 7
R 1 3 3

// ==== tb_pel.sv ====
// Processing line testbench
`timescale 1ns/100ps
`default_nettype none

`include "pel_config.svh"

module tb_pel;

    localparam int NCOL    = `NUMPEB * `KERNEL_SIZE;
    localparam int TIMEOUT = 20;

    logic                clk;
    logic                rst;
    logic                fnh_frm;
    pel_pkg::act_beat_t  beat;
    logic                rdy_act;
    logic                get_act;
    logic [NCOL-1:0]     rdy_wei;
    logic [NCOL-1:0]     get_wei;
    pel_pkg::wei_row_t   wei;
    pel_pkg::peb_sel_t   en_rd;
    pel_pkg::psum_addr_t addr_rd;
    pel_pkg::psum_t      pool_dat;

    // Columns loaded since the last frame end
    logic [NCOL-1:0]     loaded_model;
    logic                aborted;
    int test_id, test_checks, test_errs, total_checks, total_errs;

    pel DUT (
        .clk      (clk),
        .rst      (rst),
        .fnh_frm  (fnh_frm),
        .beat     (beat),
        .rdy_act  (rdy_act),
        .get_act  (get_act),
        .rdy_wei  (rdy_wei),
        .get_wei  (get_wei),
        .wei      (wei),
        .en_rd    (en_rd),
        .addr_rd  (addr_rd),
        .pool_dat (pool_dat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // Helpers, all entered and left just after a falling edge
    // ========================================================================

    // Channel 0 in the low byte
    function automatic pel_pkg::act_vec_t pack_vec(input int v0, v1, v2, v3);
        return {v3[`DATA_WIDTH-1:0], v2[`DATA_WIDTH-1:0],
                v1[`DATA_WIDTH-1:0], v0[`DATA_WIDTH-1:0]};
    endfunction

    task automatic check(input logic ok, input string what);
        test_checks++;
        assert (ok) else begin
            $display("FAILED at %0t ns: %s", $time, what);
            test_errs++;
        end
    endtask

    task automatic close_test();
        $display("test %0d done: %0d checks, %0d errors", test_id, test_checks, test_errs);
        total_checks += test_checks;
        total_errs   += test_errs;
        test_checks  = 0;
        test_errs    = 0;
    endtask

    // get_wei mirrors the empty columns, get_act needs block 0 full
    task automatic check_strobes(input string when);
        check(get_wei == ~loaded_model, $sformatf("get_wei %b %s", get_wei, when));
        check(get_act == &loaded_model[`KERNEL_SIZE-1:0],
              $sformatf("get_act %b %s", get_act, when));
    endtask

    task automatic load_weight(input int blk, col, input logic [3:0] flg,
                               input int w0, w1, w2, w3);
        int idx;
        int n;
        idx     = blk * `KERNEL_SIZE + col;
        wei.flg = flg;
        wei.wei = pack_vec(w0, w1, w2, w3);
        rdy_wei[idx] = 1'b1;
        n = 0;
        while (!get_wei[idx] && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!get_wei[idx]) begin
            $display("timeout: column %0d of block %0d never asked for weights", col, blk);
            aborted = 1'b1;
        end
        // Transfer on the rising edge in between
        @(negedge clk);
        rdy_wei[idx] = 1'b0;
        if (!aborted) begin
            loaded_model[idx] = 1'b1;
            check_strobes($sformatf("after load of block %0d column %0d", blk, col));
        end
    endtask

    task automatic send_beat(input logic [2:0] mrk, input logic [3:0] flg,
                             input int a0, a1, a2, a3);
        int n;
        beat.frt_blk     = mrk[2];
        beat.frt_act_row = mrk[1];
        beat.val_psum    = mrk[0];
        beat.flg         = flg;
        beat.act         = pack_vec(a0, a1, a2, a3);
        rdy_act = 1'b1;
        n = 0;
        while (!get_act && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!get_act) begin
            $display("timeout: line never accepted an activation beat");
            aborted = 1'b1;
        end
        @(negedge clk);
        rdy_act = 1'b0;
    endtask

    // Entry shows on pool_dat one cycle after the request
    task automatic read_entry(input int blk, addr, expv);
        en_rd   = blk[$bits(pel_pkg::peb_sel_t)-1:0];
        addr_rd = addr[$bits(pel_pkg::psum_addr_t)-1:0];
        @(negedge clk);
        check(pool_dat == pel_pkg::psum_t'(expv),
              $sformatf("block %0d entry %0d: pool_dat %0d, expected %0d",
                        blk, addr, pool_dat, expv));
    endtask

    task automatic finish_frame();
        fnh_frm = 1'b1;
        @(negedge clk);
        fnh_frm      = 1'b0;
        loaded_model = '0;
        check_strobes("after frame finish");
    endtask

    // ========================================================================
    // Trace playback
    // ========================================================================

    initial begin
        int             fd;
        int             code;
        int             blk, col, num, v0, v1, v2, v3;
        logic [2:0]     mrk;
        logic [3:0]     flg;
        logic [8*4-1:0] tok;
        logic [8*128-1:0] rest;
        logic           done;
        clk_init_inputs: begin
            rst      = 1'b1;
            fnh_frm  = 1'b0;
            beat     = '0;
            rdy_act  = 1'b0;
            rdy_wei  = '0;
            wei      = '0;
            en_rd    = '0;
            addr_rd  = '0;
        end
        loaded_model = '0;
        aborted      = 1'b0;
        done         = 1'b0;
        test_id      = 1;
        test_checks  = 0;
        test_errs    = 0;
        total_checks = 0;
        total_errs   = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_strobes("after reset");
        fd = $fopen("pel_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open pel_trace.txt");
            aborted = 1'b1;
        end
        while (!aborted && !done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (tok)
                    "#": code = $fgets(rest, fd);
                    "W": begin
                        code = $fscanf(fd, "%d %d %b %d %d %d %d",
                                       blk, col, flg, v0, v1, v2, v3);
                        load_weight(blk, col, flg, v0, v1, v2, v3);
                    end
                    "A": begin
                        code = $fscanf(fd, "%b %b %d %d %d %d", mrk, flg, v0, v1, v2, v3);
                        send_beat(mrk, flg, v0, v1, v2, v3);
                    end
                    "D": repeat (`NUMPEB + 1) @(negedge clk);
                    "R": begin
                        code = $fscanf(fd, "%d %d %d", blk, col, num);
                        read_entry(blk, col, num);
                    end
                    "F": finish_frame();
                    "T": begin
                        code = $fscanf(fd, "%d", num);
                        close_test();
                        test_id = num;
                    end
                    default: begin
                        $display("unknown command in pel_trace.txt");
                        aborted = 1'b1;
                    end
                endcase
            end
        end
        close_test();
        $display("checks %0d, errors %0d", total_checks, total_errs);
        if (aborted || total_errs != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pel.sv ====
// Processing line top
`timescale 1ns/100ps
`default_nettype none

`include "pel_config.svh"

module pel (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                fnh_frm,
    input  pel_pkg::act_beat_t                  beat,
    input  logic                                rdy_act,
    output logic                                get_act,
    input  logic [`NUMPEB*`KERNEL_SIZE-1:0]     rdy_wei,
    output logic [`NUMPEB*`KERNEL_SIZE-1:0]     get_wei,
    input  pel_pkg::wei_row_t                   wei,
    input  pel_pkg::peb_sel_t                   en_rd,
    input  pel_pkg::psum_addr_t                 addr_rd,
    output pel_pkg::psum_t                      pool_dat
);

    // Chain taps, entry i feeds block i
    pel_pkg::act_beat_t chain_beat [`NUMPEB+1];
    logic               chain_rdy  [`NUMPEB+1];
    logic               chain_get  [`NUMPEB+1];
    pel_pkg::psum_t     blk_dat    [`NUMPEB];
    pel_pkg::peb_sel_t  en_rd_q;

    // ====================================================================
    // Block chain
    // ====================================================================

    assign chain_beat[0] = beat;
    assign chain_rdy[0]  = rdy_act;
    assign get_act       = chain_get[0];

    // Last block always drains
    assign chain_get[`NUMPEB] = 1'b1;

    for (genvar i = 0; i < `NUMPEB; i++) begin : g_peb
        peb u_peb (
            .clk         (clk),
            .rst         (rst),
            .fnh_frm     (fnh_frm),
            .rdy_wei     (rdy_wei[i*`KERNEL_SIZE +: `KERNEL_SIZE]),
            .get_wei     (get_wei[i*`KERNEL_SIZE +: `KERNEL_SIZE]),
            .wei         (wei),
            .lst_beat    (chain_beat[i]),
            .lst_rdy_act (chain_rdy[i]),
            .lst_get_act (chain_get[i]),
            .nxt_beat    (chain_beat[i+1]),
            .nxt_rdy_act (chain_rdy[i+1]),
            .nxt_get_act (chain_get[i+1]),
            .addr_rd     (addr_rd),
            .rd_dat      (blk_dat[i])
        );
    end

    // ====================================================================
    // Pool read select
    // ====================================================================

    // Select delayed to line up with the block read register
    always_ff @(posedge clk) begin
        if (rst) begin
            en_rd_q <= '0;
        end else begin
            en_rd_q <= en_rd;
        end
    end

    assign pool_dat = blk_dat[en_rd_q];

    a_en_rd_range : assert property (
        @(posedge clk) disable iff (rst)
        int'(en_rd) < `NUMPEB
    );

endmodule

`default_nettype wire

// ==== peb.sv ====
// Processing block
`timescale 1ns/100ps
`default_nettype none

`include "pel_config.svh"

module peb (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fnh_frm,
    input  logic [`KERNEL_SIZE-1:0]   rdy_wei,
    output logic [`KERNEL_SIZE-1:0]   get_wei,
    input  pel_pkg::wei_row_t         wei,
    input  pel_pkg::act_beat_t        lst_beat,
    input  logic                      lst_rdy_act,
    output logic                      lst_get_act,
    output pel_pkg::act_beat_t        nxt_beat,
    output logic                      nxt_rdy_act,
    input  logic                      nxt_get_act,
    input  pel_pkg::psum_addr_t       addr_rd,
    output pel_pkg::psum_t            rd_dat
);

    logic [`KERNEL_SIZE-1:0] col_loaded;
    pel_pkg::psum_t          prod     [`KERNEL_SIZE];
    logic                    take;
    logic                    clr;
    pel_pkg::row_idx_t       row_q;
    pel_pkg::row_idx_t       cur_row;
    pel_pkg::psum_t          psum_q   [`LENPSUM];
    pel_pkg::psum_t          psum_nxt [`LENPSUM];
    pel_pkg::act_beat_t      fwd_beat;
    logic                    fwd_vld;

    // ====================================================================
    // Columns, column k holds kernel row k
    // ====================================================================

    for (genvar k = 0; k < `KERNEL_SIZE; k++) begin : g_col
        pec u_pec (
            .clk     (clk),
            .rst     (rst),
            .fnh_frm (fnh_frm),
            .rdy_wei (rdy_wei[k]),
            .get_wei (get_wei[k]),
            .wei     (wei),
            .loaded  (col_loaded[k]),
            .act     (lst_beat.act),
            .act_flg (lst_beat.flg),
            .prod    (prod[k])
        );
    end

    // ====================================================================
    // Acceptance and row tracking
    // ====================================================================

    // All weights present and forward slot free or draining
    assign lst_get_act = (&col_loaded) && (!fwd_vld || nxt_get_act);
    assign take        = lst_rdy_act && lst_get_act;

    // Row index of the incoming beat
    assign cur_row = lst_beat.frt_act_row ? '0 : row_q + 1'b1;

    // First row of a first channel block starts fresh sums
    assign clr = lst_beat.frt_blk && lst_beat.frt_act_row;

    always_ff @(posedge clk) begin
        if (rst) begin
            row_q <= '0;
        end else if (take) begin
            row_q <= cur_row;
        end
    end

    // ====================================================================
    // Partial-sum buffer
    // ====================================================================

    // Column k lands on output row cur_row - k
    always_comb begin
        for (int e = 0; e < `LENPSUM; e++) begin
            psum_nxt[e] = clr ? '0 : psum_q[e];
            for (int k = 0; k < `KERNEL_SIZE; k++) begin
                if (lst_beat.val_psum && int'(cur_row) == e + k) begin
                    psum_nxt[e] = psum_nxt[e] + prod[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < `LENPSUM; e++) begin
                psum_q[e] <= '0;
            end
        end else if (take) begin
            psum_q <= psum_nxt;
        end
    end

    // Registered read for the pooling stage
    always_ff @(posedge clk) begin
        rd_dat <= psum_q[addr_rd];
    end

    // ====================================================================
    // Forwarding stage
    // ====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_vld <= 1'b0;
        end else if (take) begin
            fwd_vld <= 1'b1;
        end else if (nxt_get_act) begin
            fwd_vld <= 1'b0;
        end
    end

    // Beat payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            fwd_beat <= lst_beat;
        end
    end

    assign nxt_beat    = fwd_beat;
    assign nxt_rdy_act = fwd_vld;

    // Accepted beats only meet columns that have stopped asking for weights
    a_take_loaded : assert property (
        @(posedge clk) disable iff (rst)
        take |-> (get_wei == '0)
    );

endmodule

`default_nettype wire

// ==== pec.sv ====
// Processing column
`timescale 1ns/100ps
`default_nettype none

`include "pel_config.svh"

module pec (
    input  logic               clk,
    input  logic               rst,
    input  logic               fnh_frm,
    input  logic               rdy_wei,
    output logic               get_wei,
    input  pel_pkg::wei_row_t  wei,
    output logic               loaded,
    input  pel_pkg::act_vec_t  act,
    input  pel_pkg::flag_t     act_flg,
    output pel_pkg::psum_t     prod
);

    // ====================================================================
    // Weight row register
    // ====================================================================

    pel_pkg::wei_row_t wei_q;
    logic              loaded_q;
    logic              load;

    // Column asks for a row while empty
    assign get_wei = !loaded_q;
    assign loaded  = loaded_q;

    // rdy/get transfer
    assign load = rdy_wei && get_wei;

    // Loaded flag, emptied at frame end
    always_ff @(posedge clk) begin
        if (rst) begin
            loaded_q <= 1'b0;
        end else if (fnh_frm) begin
            loaded_q <= 1'b0;
        end else if (load) begin
            loaded_q <= 1'b1;
        end
    end

    // Row payload
    always_ff @(posedge clk) begin
        if (load) begin
            wei_q <= wei;
        end
    end

    // ====================================================================
    // Flag-masked dot product
    // ====================================================================

    always_comb begin : dot
        pel_pkg::psum_t acc;
        pel_pkg::data_t a_ch;
        pel_pkg::data_t w_ch;
        acc = '0;
        for (int c = 0; c < `BLOCK_DEPTH; c++) begin
            a_ch = act[c*`DATA_WIDTH +: `DATA_WIDTH];
            w_ch = wei_q.wei[c*`DATA_WIDTH +: `DATA_WIDTH];
            // Skip channel unless both values are nonzero
            if (act_flg[c] && wei_q.flg[c]) begin
                acc = acc + a_ch * w_ch;
            end
        end
        prod = acc;
    end

    // ====================================================================
    // Checks
    // ====================================================================

    // Once loaded, no further row is taken until the frame finishes
    a_no_reload : assert property (
        @(posedge clk) disable iff (rst)
        (load && !fnh_frm) |=> (!load until fnh_frm)
    );

endmodule

`default_nettype wire

// ==== pel_pkg.sv ====
// Processing line types
`default_nettype none

`include "pel_config.svh"

package pel_pkg;

    // ====================================================================
    // Scalar and vector types
    // ====================================================================

    // One signed activation or weight
    typedef logic signed [`DATA_WIDTH-1:0] data_t;

    // Signed partial sum
    typedef logic signed [`PSUM_WIDTH-1:0] psum_t;

    // Nonzero flags, one per channel
    typedef logic [`BLOCK_DEPTH-1:0] flag_t;

    // Channel values, channel 0 in the low byte
    typedef logic [`DATA_WIDTH*`BLOCK_DEPTH-1:0] act_vec_t;

    // Activation row index and buffer addressing
    typedef logic [`ROW_WIDTH-1:0] row_idx_t;
    typedef logic [$clog2(`LENPSUM)-1:0] psum_addr_t;
    typedef logic [$clog2(`NUMPEB)-1:0] peb_sel_t;

    // ====================================================================
    // Bundles
    // ====================================================================

    // One activation beat as it travels along the line
    typedef struct packed {
        logic     frt_blk;
        logic     frt_act_row;
        logic     val_psum;
        flag_t    flg;
        act_vec_t act;
    } act_beat_t;

    // One weight row for a single column
    typedef struct packed {
        flag_t    flg;
        act_vec_t wei;
    } wei_row_t;

endpackage

`default_nettype wire

// ==== pel_config.svh ====
// Processing line sizes
`ifndef PEL_CONFIG_SVH
`define PEL_CONFIG_SVH

// ========================================================================
// Datapath widths
// ========================================================================

// Signed activation and weight width
`define DATA_WIDTH 8

// Channels carried by one activation beat
`define BLOCK_DEPTH 4

// Partial sum width, product width plus growth headroom
`define PSUM_WIDTH (2 * `DATA_WIDTH + 4)

// Activation row index width
`define ROW_WIDTH 3

// ========================================================================
// Line geometry
// ========================================================================

// Columns per block, one per kernel row
`define KERNEL_SIZE 3

// Blocks chained in the line
`define NUMPEB 2

// Output rows held in each partial-sum buffer
`define LENPSUM 4

`endif
